// ==== common/game_pkg.sv ====
`default_nettype none

package game_pkg;

	// ========================================
	// board geometry and game constants
	// ========================================
	localparam int board_size = 4;
	localparam int cell_count = board_size * board_size;
	localparam int win_exp = 11;

	// fibonacci lfsr, taps 16 14 13 11 map to bits 15 13 12 10.
	localparam logic [15:0] lfsr_seed = 16'hace1;
	localparam logic [15:0] lfsr_taps = 16'hb400;

	// ========================================
	// types
	// ========================================
	typedef logic [3:0] exp_t;
	typedef logic [3:0] cell_addr_t;

	typedef enum logic [1:0]
	{
		dir_left,
		dir_right,
		dir_up,
		dir_down
	} dir_e;

	typedef enum logic [3:0]
	{
		state_idle,
		state_gen_first,
		state_gen_second,
		state_wait_move,
		state_shift,
		state_spawn,
		state_check,
		state_win,
		state_lose
	} game_state_e;

	typedef enum logic [1:0]
	{
		master_shifter,
		master_scanner,
		master_host
	} master_e;

endpackage

`default_nettype wire

// ==== common/board_bus_if.sv ====
`default_nettype none

// one master's view of the shared board memory.
interface board_bus_if;

	logic req;
	logic we;
	game_pkg::cell_addr_t addr;
	game_pkg::exp_t wdata;
	logic gnt;
	game_pkg::exp_t rdata;
	logic rvalid;

	modport master
	(
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata,
		input rvalid
	);

	modport arbiter
	(
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

`default_nettype wire

// ==== board/board_ram.sv ====
`default_nettype none

module board_ram
(
	input logic clk,
	input logic rst,
	input logic we,
	input game_pkg::cell_addr_t addr,
	input game_pkg::exp_t wdata,
	output game_pkg::exp_t rdata,
	input logic clear
);

	game_pkg::exp_t mem [game_pkg::cell_count];

	// the board starts empty and is wiped again when a finished game is acknowledged.
	always_ff @(posedge clk)
	begin
		if (rst || clear)
		begin
			for (int i = 0; i < game_pkg::cell_count; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (we)
		begin
			mem[addr] <= wdata;
		end
	end

	// read data shows up one cycle after the access.
	always_ff @(posedge clk)
	begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== board/board_arbiter.sv ====
`default_nettype none

module board_arbiter
(
	input logic clk,
	input logic rst,
	board_bus_if.arbiter shifter_bus,
	board_bus_if.arbiter scanner_bus,
	board_bus_if.arbiter host_bus,
	output logic ram_we,
	output game_pkg::cell_addr_t ram_addr,
	output game_pkg::exp_t ram_wdata,
	input game_pkg::exp_t ram_rdata
);

	game_pkg::master_e sel;
	logic any_req;
	logic rd_pending;
	game_pkg::master_e rd_master;

	// fixed priority, shifter first and host last.
	always_comb
	begin
		any_req = shifter_bus.req || scanner_bus.req || host_bus.req;
		sel = game_pkg::master_host;
		ram_we = 1'b0;
		ram_addr = host_bus.addr;
		ram_wdata = host_bus.wdata;
		if (shifter_bus.req)
		begin
			sel = game_pkg::master_shifter;
			ram_we = shifter_bus.we;
			ram_addr = shifter_bus.addr;
			ram_wdata = shifter_bus.wdata;
		end
		else if (scanner_bus.req)
		begin
			sel = game_pkg::master_scanner;
			ram_we = scanner_bus.we;
			ram_addr = scanner_bus.addr;
			ram_wdata = scanner_bus.wdata;
		end
		else if (host_bus.req)
		begin
			ram_we = host_bus.we;
		end
	end

	assign shifter_bus.gnt = shifter_bus.req;
	assign scanner_bus.gnt = scanner_bus.req && !shifter_bus.req;
	assign host_bus.gnt = host_bus.req && !shifter_bus.req && !scanner_bus.req;

	// remember who owns the read that is in flight.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_pending <= 1'b0;
			rd_master <= game_pkg::master_host;
		end
		else
		begin
			rd_pending <= any_req && !ram_we;
			rd_master <= sel;
		end
	end

	assign shifter_bus.rvalid = rd_pending && (rd_master == game_pkg::master_shifter);
	assign scanner_bus.rvalid = rd_pending && (rd_master == game_pkg::master_scanner);
	assign host_bus.rvalid = rd_pending && (rd_master == game_pkg::master_host);

	assign shifter_bus.rdata = shifter_bus.rvalid ? ram_rdata : '0;
	assign scanner_bus.rdata = scanner_bus.rvalid ? ram_rdata : '0;
	assign host_bus.rdata = host_bus.rvalid ? ram_rdata : '0;

endmodule

`default_nettype wire

// ==== logic/line_shifter.sv ====
`default_nettype none

module line_shifter
(
	input logic clk,
	input logic rst,
	board_bus_if.master bus,
	input logic shift_start,
	input game_pkg::dir_e dir,
	output logic shift_done,
	output logic moved
);

	typedef enum logic [2:0]
	{
		ls_idle,
		ls_rd_req,
		ls_rd_wait,
		ls_merge,
		ls_wr_req
	} ls_state_e;

	ls_state_e ls_state;
	game_pkg::dir_e dir_q;
	logic [1:0] line_idx;
	logic [1:0] pos;
	game_pkg::exp_t [3:0] cur_line;
	game_pkg::exp_t [3:0] new_line;
	game_pkg::exp_t [3:0] merged;

	// position 0 is the leading edge, the side the tiles slide toward.
	function automatic game_pkg::cell_addr_t cell_addr(input game_pkg::dir_e d,
		input logic [1:0] line, input logic [1:0] p);
		case (d)
			game_pkg::dir_left:
				return {line, p};
			game_pkg::dir_right:
				return {line, 2'd3 - p};
			game_pkg::dir_up:
				return {p, line};
			default:
				return {2'd3 - p, line};
		endcase
	endfunction

	// pack the non-zero tiles, then merge equal pairs once each from the leading edge.
	function automatic logic [15:0] slide_line(input game_pkg::exp_t [3:0] in_line);
		game_pkg::exp_t [4:0] packed_v;
		game_pkg::exp_t [3:0] result;
		int n;
		int k;
		logic skip;
		packed_v = '0;
		result = '0;
		n = 0;
		k = 0;
		skip = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			if (in_line[i] != '0)
			begin
				packed_v[n] = in_line[i];
				n++;
			end
		end
		for (int i = 0; i < 4; i++)
		begin
			if (skip)
				skip = 1'b0;
			else if (packed_v[i] != '0)
			begin
				result[k] = packed_v[i];
				if (packed_v[i] == packed_v[i + 1])
				begin
					result[k] = packed_v[i] + 4'd1;
					skip = 1'b1;
				end
				k++;
			end
		end
		return result;
	endfunction

	assign merged = slide_line(cur_line);

	assign bus.req = (ls_state == ls_rd_req) || (ls_state == ls_wr_req);
	assign bus.we = (ls_state == ls_wr_req);
	assign bus.addr = cell_addr(dir_q, line_idx, pos);
	assign bus.wdata = new_line[pos];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ls_state <= ls_idle;
			line_idx <= '0;
			pos <= '0;
			shift_done <= 1'b0;
			moved <= 1'b0;
		end
		else
		begin
			shift_done <= 1'b0;
			case (ls_state)
				ls_idle:
				begin
					if (shift_start)
					begin
						dir_q <= dir;
						line_idx <= '0;
						pos <= 2'd3;
						moved <= 1'b0;
						ls_state <= ls_rd_req;
					end
				end
				ls_rd_req:
				begin
					if (bus.gnt)
						ls_state <= ls_rd_wait;
				end
				ls_rd_wait:
				begin
					if (bus.rvalid)
					begin
						cur_line[pos] <= bus.rdata;
						if (pos == '0)
							ls_state <= ls_merge;
						else
						begin
							pos <= pos - 2'd1;
							ls_state <= ls_rd_req;
						end
					end
				end
				ls_merge:
				begin
					new_line <= merged;
					if (merged != cur_line)
						moved <= 1'b1;
					ls_state <= ls_wr_req;
				end
				ls_wr_req:
				begin
					if (bus.gnt)
					begin
						pos <= pos + 2'd1;
						if (pos == 2'd3 && line_idx == 2'd3)
						begin
							shift_done <= 1'b1;
							ls_state <= ls_idle;
						end
						else if (pos == 2'd3)
						begin
							// the next line is read from its far edge again.
							line_idx <= line_idx + 2'd1;
							pos <= 2'd3;
							ls_state <= ls_rd_req;
						end
					end
				end
				default:
				begin
					ls_state <= ls_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/board_scanner.sv ====
`default_nettype none

module board_scanner
(
	input logic clk,
	input logic rst,
	board_bus_if.master bus,
	input logic scan_start,
	input logic spawn,
	output logic scan_done,
	output logic [4:0] empty_count,
	output game_pkg::exp_t max_exp,
	output logic can_merge
);

	typedef enum logic [2:0]
	{
		sc_idle,
		sc_rd_req,
		sc_rd_wait,
		sc_step,
		sc_pick,
		sc_wr_req
	} sc_state_e;

	sc_state_e sc_state;
	logic spawn_q;
	game_pkg::cell_addr_t idx;
	logic [15:0] empty_mask;
	game_pkg::exp_t [3:0] hist;
	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	logic cell_empty;
	logic [4:0] empty_next;
	logic [4:0] spawn_rank;
	game_pkg::cell_addr_t spawn_addr;
	game_pkg::exp_t spawn_val;

	// returns the address of the empty cell with the given rank.
	function automatic game_pkg::cell_addr_t pick_empty(input logic [15:0] mask,
		input logic [4:0] rank);
		game_pkg::cell_addr_t sel;
		logic [4:0] seen;
		sel = '0;
		seen = '0;
		for (int i = 0; i < game_pkg::cell_count; i++)
		begin
			if (mask[i])
			begin
				if (seen == rank)
					sel = game_pkg::cell_addr_t'(i);
				seen = seen + 5'd1;
			end
		end
		return sel;
	endfunction

	assign lfsr_next = {lfsr[14:0], ^(lfsr & game_pkg::lfsr_taps)};
	assign cell_empty = (bus.rdata == '0);
	assign empty_next = empty_count + 5'(cell_empty);
	assign spawn_rank = 5'(lfsr % {11'd0, empty_count});

	assign bus.req = (sc_state == sc_rd_req) || (sc_state == sc_wr_req);
	assign bus.we = (sc_state == sc_wr_req);
	assign bus.addr = (sc_state == sc_wr_req) ? spawn_addr : idx;
	assign bus.wdata = spawn_val;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sc_state <= sc_idle;
			spawn_q <= 1'b0;
			idx <= '0;
			lfsr <= game_pkg::lfsr_seed;
			scan_done <= 1'b0;
			empty_count <= '0;
			max_exp <= '0;
			can_merge <= 1'b0;
		end
		else
		begin
			scan_done <= 1'b0;
			case (sc_state)
				sc_idle:
				begin
					if (scan_start)
					begin
						spawn_q <= spawn;
						idx <= '0;
						empty_count <= '0;
						max_exp <= '0;
						can_merge <= 1'b0;
						sc_state <= sc_rd_req;
					end
				end
				sc_rd_req:
				begin
					if (bus.gnt)
						sc_state <= sc_rd_wait;
				end
				sc_rd_wait:
				begin
					if (bus.rvalid)
					begin
						empty_mask[idx] <= cell_empty;
						empty_count <= empty_next;
						if (bus.rdata > max_exp)
							max_exp <= bus.rdata;
						// hist[0] is the left neighbour, hist[3] the cell above.
						if (!cell_empty && ((idx[1:0] != '0 && bus.rdata == hist[0]) ||
							(idx[3:2] != '0 && bus.rdata == hist[3])))
							can_merge <= 1'b1;
						hist <= {hist[2:0], bus.rdata};
						idx <= idx + 4'd1;
						if (idx != 4'd15)
							sc_state <= sc_rd_req;
						else if (spawn_q && empty_next != '0)
							sc_state <= sc_step;
						else
						begin
							scan_done <= 1'b1;
							sc_state <= sc_idle;
						end
					end
				end
				sc_step:
				begin
					lfsr <= lfsr_next;
					sc_state <= sc_pick;
				end
				sc_pick:
				begin
					spawn_addr <= pick_empty(empty_mask, spawn_rank);
					spawn_val <= (lfsr[3:0] == 4'd0) ? 4'd2 : 4'd1;
					sc_state <= sc_wr_req;
				end
				sc_wr_req:
				begin
					if (bus.gnt)
					begin
						scan_done <= 1'b1;
						sc_state <= sc_idle;
					end
				end
				default:
				begin
					sc_state <= sc_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/game_fsm.sv ====
`default_nettype none

module game_fsm
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic ack,
	input logic move_valid,
	input game_pkg::dir_e dir,
	output logic move_ready,
	output logic busy,
	output logic win,
	output logic lose,
	output game_pkg::game_state_e state,
	output logic shift_start,
	output game_pkg::dir_e shift_dir,
	input logic shift_done,
	input logic moved,
	output logic scan_start,
	output logic spawn,
	input logic scan_done,
	input logic [4:0] empty_count,
	input game_pkg::exp_t max_exp,
	input logic can_merge,
	output logic board_clear
);

	// ========================================
	// state register
	// ========================================
	// each worker gets its start pulse on the edge that enters the state
	// which waits for it.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= game_pkg::state_idle;
			shift_start <= 1'b0;
			shift_dir <= game_pkg::dir_left;
			scan_start <= 1'b0;
			spawn <= 1'b0;
		end
		else
		begin
			shift_start <= 1'b0;
			scan_start <= 1'b0;
			case (state)
				game_pkg::state_idle:
				begin
					if (start)
					begin
						state <= game_pkg::state_gen_first;
						scan_start <= 1'b1;
						spawn <= 1'b1;
					end
				end
				game_pkg::state_gen_first:
				begin
					if (scan_done)
					begin
						state <= game_pkg::state_gen_second;
						scan_start <= 1'b1;
						spawn <= 1'b1;
					end
				end
				game_pkg::state_gen_second:
				begin
					if (scan_done)
					begin
						state <= game_pkg::state_wait_move;
					end
				end
				game_pkg::state_wait_move:
				begin
					if (move_valid)
					begin
						state <= game_pkg::state_shift;
						shift_start <= 1'b1;
						shift_dir <= dir;
					end
				end
				game_pkg::state_shift:
				begin
					if (shift_done && moved)
					begin
						state <= game_pkg::state_spawn;
						scan_start <= 1'b1;
						spawn <= 1'b1;
					end
					else if (shift_done)
					begin
						state <= game_pkg::state_wait_move;
					end
				end
				game_pkg::state_spawn:
				begin
					if (scan_done)
					begin
						state <= game_pkg::state_check;
						scan_start <= 1'b1;
						spawn <= 1'b0;
					end
				end
				game_pkg::state_check:
				begin
					if (scan_done)
					begin
						if (max_exp >= game_pkg::exp_t'(game_pkg::win_exp))
							state <= game_pkg::state_win;
						else if (empty_count == '0 && !can_merge)
							state <= game_pkg::state_lose;
						else
							state <= game_pkg::state_wait_move;
					end
				end
				game_pkg::state_win, game_pkg::state_lose:
				begin
					if (ack)
					begin
						state <= game_pkg::state_idle;
					end
				end
				default:
				begin
					state <= game_pkg::state_idle;
				end
			endcase
		end
	end

	// ========================================
	// status outputs
	// ========================================
	assign move_ready = (state == game_pkg::state_wait_move);
	assign win = (state == game_pkg::state_win);
	assign lose = (state == game_pkg::state_lose);
	assign busy = !(move_ready || win || lose || state == game_pkg::state_idle);
	assign board_clear = (win || lose) && ack;

endmodule

`default_nettype wire

// ==== logic/game_top.sv ====
`default_nettype none

module game_top
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic ack,
	input logic move_valid,
	input game_pkg::dir_e dir,
	output logic move_ready,
	output logic busy,
	output logic win,
	output logic lose,
	output game_pkg::game_state_e state,
	input logic host_req,
	input logic host_we,
	input game_pkg::cell_addr_t host_addr,
	input game_pkg::exp_t host_wdata,
	output logic host_gnt,
	output game_pkg::exp_t host_rdata,
	output logic host_rvalid
);

	logic ram_we;
	game_pkg::cell_addr_t ram_addr;
	game_pkg::exp_t ram_wdata;
	game_pkg::exp_t ram_rdata;
	logic board_clear;
	logic shift_start;
	game_pkg::dir_e shift_dir;
	logic shift_done;
	logic moved;
	logic scan_start;
	logic spawn;
	logic scan_done;
	logic [4:0] empty_count;
	game_pkg::exp_t max_exp;
	logic can_merge;

	board_bus_if shifter_bus();
	board_bus_if scanner_bus();
	board_bus_if host_bus();

	// the host port is the testbench's window onto the board.
	assign host_bus.req = host_req;
	assign host_bus.we = host_we;
	assign host_bus.addr = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_gnt = host_bus.gnt;
	assign host_rdata = host_bus.rdata;
	assign host_rvalid = host_bus.rvalid;

	board_ram u_ram (.clk, .rst, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
		.rdata(ram_rdata), .clear(board_clear));

	board_arbiter u_arbiter (.clk, .rst, .shifter_bus, .scanner_bus, .host_bus,
		.ram_we, .ram_addr, .ram_wdata, .ram_rdata);

	line_shifter u_shifter (.clk, .rst, .bus(shifter_bus), .shift_start,
		.dir(shift_dir), .shift_done, .moved);

	board_scanner u_scanner (.clk, .rst, .bus(scanner_bus), .scan_start, .spawn,
		.scan_done, .empty_count, .max_exp, .can_merge);

	game_fsm u_fsm (.clk, .rst, .start, .ack, .move_valid, .dir, .move_ready, .busy,
		.win, .lose, .state, .shift_start, .shift_dir, .shift_done, .moved, .scan_start,
		.spawn, .scan_done, .empty_count, .max_exp, .can_merge, .board_clear);

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`default_nettype none

// free-running clock with a period of 100, reset held over the first two edges.
module clk_gen
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#50 clk = ~clk;
		end
	end

	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/game_sva.sv ====
`default_nettype none

module game_sva
(
	input logic clk,
	input logic rst,
	input logic [2:0] gnt,
	input logic [2:0] rd_gnt,
	input logic [2:0] rvalid,
	input logic move_ready,
	input logic move_valid,
	input game_pkg::game_state_e state
);

	// the memory belongs to one master at a time.
	assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
		else $error("more than one master granted in the same cycle");

	// read data returns to the master that was granted the read, one cycle later.
	assert property (@(posedge clk) disable iff (rst) (|rd_gnt) |=> (rvalid == $past(rd_gnt)))
		else $error("rvalid did not follow a granted read by one cycle");

	// an offered move starts a shift, otherwise the machine keeps waiting for one.
	assert property (@(posedge clk) disable iff (rst)
		move_ready |=> ($past(move_valid) ? state == game_pkg::state_shift : move_ready))
		else $error("wait_move did not answer move_valid correctly");

endmodule

// ========================================
// attachment points
// ========================================
bind board_arbiter game_sva arbiter_checks
(
	.clk(clk),
	.rst(rst),
	.gnt({host_bus.gnt, scanner_bus.gnt, shifter_bus.gnt}),
	.rd_gnt({host_bus.gnt && !host_bus.we, scanner_bus.gnt && !scanner_bus.we,
		shifter_bus.gnt && !shifter_bus.we}),
	.rvalid({host_bus.rvalid, scanner_bus.rvalid, shifter_bus.rvalid}),
	.move_ready(1'b0),
	.move_valid(1'b0),
	.state(game_pkg::state_wait_move)
);

bind game_fsm game_sva fsm_checks
(
	.clk(clk),
	.rst(rst),
	.gnt(3'b000),
	.rd_gnt(3'b000),
	.rvalid(3'b000),
	.move_ready(move_ready),
	.move_valid(move_valid),
	.state(state)
);

`default_nettype wire

// ==== verification/game_tb.sv ====
`default_nettype none

module game_tb;

	localparam int entry_count = 5;
	localparam int max_moves = 4;

	logic clk;
	logic gen_rst;
	logic tb_rst;
	logic rst;
	logic start;
	logic ack;
	logic move_valid;
	game_pkg::dir_e dir;
	logic move_ready;
	logic busy;
	logic win;
	logic lose;
	game_pkg::game_state_e state;
	logic host_req;
	logic host_we;
	game_pkg::cell_addr_t host_addr;
	game_pkg::exp_t host_wdata;
	logic host_gnt;
	game_pkg::exp_t host_rdata;
	logic host_rvalid;

	int cell_errors = 0;
	int flag_errors = 0;
	int state_errors = 0;

	game_pkg::exp_t model_board [game_pkg::cell_count];
	logic [15:0] model_lfsr;

	// ========================================
	// test table
	// ========================================
	// boards read row by row, cell 0 in the top nibble.
	logic [63:0] table_board [entry_count] = '{
		64'h0000_0000_0000_0000,
		64'h1122_1110_0202_3033,
		64'h3434_5656_0789_0987,
		64'haa00_0000_0000_0000,
		64'h3356_5453_6767_0890
	};
	game_pkg::dir_e table_moves [entry_count][max_moves] = '{
		'{game_pkg::dir_left, game_pkg::dir_up, game_pkg::dir_right, game_pkg::dir_down},
		'{game_pkg::dir_left, game_pkg::dir_right, game_pkg::dir_up, game_pkg::dir_down},
		'{game_pkg::dir_left, game_pkg::dir_left, game_pkg::dir_left, game_pkg::dir_left},
		'{game_pkg::dir_left, game_pkg::dir_left, game_pkg::dir_left, game_pkg::dir_left},
		'{game_pkg::dir_left, game_pkg::dir_left, game_pkg::dir_left, game_pkg::dir_left}
	};
	int table_move_count [entry_count] = '{4, 4, 1, 1, 1};
	game_pkg::game_state_e table_end [entry_count] = '{game_pkg::state_wait_move,
		game_pkg::state_wait_move, game_pkg::state_wait_move, game_pkg::state_win,
		game_pkg::state_lose};

	clk_gen clock (.clk(clk), .rst(gen_rst));

	assign rst = gen_rst || tb_rst;

	game_top UUT (.clk, .rst, .start, .ack, .move_valid, .dir, .move_ready, .busy, .win,
		.lose, .state, .host_req, .host_we, .host_addr, .host_wdata, .host_gnt, .host_rdata,
		.host_rvalid);

	// ========================================
	// reference model
	// ========================================
	function automatic int line_cell(input game_pkg::dir_e d, input int line, input int p);
		case (d)
			game_pkg::dir_left: return line * 4 + p;
			game_pkg::dir_right: return line * 4 + 3 - p;
			game_pkg::dir_up: return p * 4 + line;
			default: return (3 - p) * 4 + line;
		endcase
	endfunction

	// slides every line toward the leading edge and returns whether the board changed.
	function automatic logic model_move(input game_pkg::dir_e d);
		game_pkg::exp_t vals [$];
		game_pkg::exp_t out_line [4];
		logic changed;
		int i;
		int k;
		changed = 1'b0;
		for (int line = 0; line < 4; line++)
		begin
			vals.delete();
			for (int p = 0; p < 4; p++)
			begin
				if (model_board[line_cell(d, line, p)] != 4'd0)
					vals.push_back(model_board[line_cell(d, line, p)]);
				out_line[p] = 4'd0;
			end
			i = 0;
			k = 0;
			while (i < vals.size())
			begin
				if (i + 1 < vals.size() && vals[i] == vals[i + 1])
				begin
					out_line[k] = vals[i] + 4'd1;
					i += 2;
				end
				else
				begin
					out_line[k] = vals[i];
					i += 1;
				end
				k++;
			end
			for (int p = 0; p < 4; p++)
			begin
				if (out_line[p] != model_board[line_cell(d, line, p)])
					changed = 1'b1;
				model_board[line_cell(d, line, p)] = out_line[p];
			end
		end
		return changed;
	endfunction

	function automatic void model_spawn();
		int empties;
		int rank;
		int seen;
		empties = 0;
		seen = 0;
		for (int i = 0; i < game_pkg::cell_count; i++)
		begin
			if (model_board[i] == 4'd0)
				empties++;
		end
		if (empties != 0)
		begin
			model_lfsr = {model_lfsr[14:0],
				model_lfsr[15] ^ model_lfsr[13] ^ model_lfsr[12] ^ model_lfsr[10]};
			rank = model_lfsr % empties;
			for (int i = 0; i < game_pkg::cell_count; i++)
			begin
				if (model_board[i] == 4'd0)
				begin
					if (seen == rank)
						model_board[i] = (model_lfsr[3:0] == 4'd0) ? 4'd2 : 4'd1;
					seen++;
				end
			end
		end
	endfunction

	function automatic game_pkg::game_state_e model_end_state();
		int empties;
		logic merge;
		game_pkg::exp_t top;
		empties = 0;
		merge = 1'b0;
		top = 4'd0;
		for (int i = 0; i < game_pkg::cell_count; i++)
		begin
			if (model_board[i] == 4'd0)
				empties++;
			if (model_board[i] > top)
				top = model_board[i];
			if (i % 4 != 3 && model_board[i] != 4'd0 && model_board[i] == model_board[i + 1])
				merge = 1'b1;
			if (i < 12 && model_board[i] != 4'd0 && model_board[i] == model_board[i + 4])
				merge = 1'b1;
		end
		if (top >= game_pkg::win_exp)
			return game_pkg::state_win;
		if (empties == 0 && !merge)
			return game_pkg::state_lose;
		return game_pkg::state_wait_move;
	endfunction

	function automatic int total_moves();
		int sum;
		sum = 0;
		for (int e = 0; e < entry_count; e++)
			sum += table_move_count[e];
		return sum;
	endfunction

	// ========================================
	// compare tasks
	// ========================================
	task automatic check_cell(input game_pkg::cell_addr_t addr, input game_pkg::exp_t got,
		input game_pkg::exp_t expected);
		if (got !== expected)
		begin
			cell_errors++;
			$display("FAIL %0t: cell %0d holds %0d, expected %0d", $time, addr, got, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			flag_errors++;
			$display("FAIL %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic check_state(input game_pkg::game_state_e got,
		input game_pkg::game_state_e expected);
		if (got !== expected)
		begin
			state_errors++;
			$display("FAIL %0t: state %s, expected %s", $time, got.name(), expected.name());
		end
	endtask

	// ========================================
	// host port and game control
	// ========================================
	task automatic wait_host_grant();
		do @(negedge clk); while (!host_gnt);
	endtask

	task automatic host_write(input game_pkg::cell_addr_t addr, input game_pkg::exp_t data);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= 1'b1;
		host_addr <= addr;
		host_wdata <= data;
		wait_host_grant();
		@(posedge clk);
		host_req <= 1'b0;
		host_we <= 1'b0;
	endtask

	task automatic host_read(input game_pkg::cell_addr_t addr, output game_pkg::exp_t data);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= 1'b0;
		host_addr <= addr;
		wait_host_grant();
		@(posedge clk);
		host_req <= 1'b0;
		do @(negedge clk); while (!host_rvalid);
		data = host_rdata;
	endtask

	task automatic compare_board();
		game_pkg::exp_t got;
		for (int i = 0; i < game_pkg::cell_count; i++)
		begin
			host_read(game_pkg::cell_addr_t'(i), got);
			check_cell(game_pkg::cell_addr_t'(i), got, model_board[i]);
		end
	endtask

	task automatic load_board(input logic [63:0] cells);
		for (int i = 0; i < game_pkg::cell_count; i++)
		begin
			model_board[i] = cells[63 - 4 * i -: 4];
			host_write(game_pkg::cell_addr_t'(i), model_board[i]);
		end
	endtask

	task automatic start_game();
		logic saw_end;
		saw_end = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		model_spawn();
		model_spawn();
		do
		begin
			@(negedge clk);
			saw_end = saw_end || win || lose;
		end
		while (!move_ready);
		check_flag("win or lose during opening", saw_end, 1'b0);
		check_state(state, game_pkg::state_wait_move);
		compare_board();
	endtask

	task automatic play_move(input game_pkg::dir_e d, input int index);
		logic changed;
		game_pkg::game_state_e expected;
		game_pkg::cell_addr_t probe;
		game_pkg::exp_t got;
		changed = model_move(d);
		if (changed)
			model_spawn();
		expected = changed ? model_end_state() : game_pkg::state_wait_move;
		@(posedge clk);
		move_valid <= 1'b1;
		dir <= d;
		@(posedge clk);
		move_valid <= 1'b0;
		// a host read during the closing check scan has to wait for a gap in the scanner's reads.
		if (changed)
		begin
			do @(negedge clk);
			while (state != game_pkg::state_check && !move_ready && !win && !lose);
			probe = game_pkg::cell_addr_t'(index * 5);
			host_read(probe, got);
			check_cell(probe, got, model_board[probe]);
		end
		do @(negedge clk); while (!(move_ready || win || lose));
		check_state(state, expected);
		check_flag("busy", busy, 1'b0);
		check_flag("move_ready", move_ready, expected == game_pkg::state_wait_move);
		check_flag("win", win, expected == game_pkg::state_win);
		check_flag("lose", lose, expected == game_pkg::state_lose);
		compare_board();
	endtask

	task automatic acknowledge_end();
		@(posedge clk);
		ack <= 1'b1;
		@(posedge clk);
		ack <= 1'b0;
		@(negedge clk);
		check_state(state, game_pkg::state_idle);
		for (int i = 0; i < game_pkg::cell_count; i++)
			model_board[i] = 4'd0;
		compare_board();
	endtask

	task automatic reset_game();
		@(posedge clk);
		tb_rst <= 1'b1;
		repeat (2) @(posedge clk);
		tb_rst <= 1'b0;
		model_lfsr = game_pkg::lfsr_seed;
		for (int i = 0; i < game_pkg::cell_count; i++)
			model_board[i] = 4'd0;
		@(negedge clk);
		check_state(state, game_pkg::state_idle);
		check_flag("busy", busy, 1'b0);
	endtask

	// ========================================
	// stimulus and report
	// ========================================
	initial
	begin : stimulus
		int total;
		start = 1'b0;
		ack = 1'b0;
		move_valid = 1'b0;
		dir = game_pkg::dir_left;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		tb_rst = 1'b0;
		model_lfsr = game_pkg::lfsr_seed;
		do @(negedge clk); while (rst);
		check_state(state, game_pkg::state_idle);
		for (int e = 0; e < entry_count; e++)
		begin
			load_board(table_board[e]);
			start_game();
			for (int m = 0; m < table_move_count[e]; m++)
				play_move(table_moves[e][m], m);
			check_state(state, table_end[e]);
			if (table_end[e] == game_pkg::state_wait_move)
				reset_game();
			else
				acknowledge_end();
		end
		total = cell_errors + flag_errors + state_errors;
		$display("errors: cell %0d, flag %0d, state %0d", cell_errors, flag_errors, state_errors);
		if (total == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		limit = 400 * total_moves() + 2000;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== game_2048.f ====
common/game_pkg.sv
common/board_bus_if.sv
board/board_ram.sv
board/board_arbiter.sv
logic/line_shifter.sv
logic/board_scanner.sv
logic/game_fsm.sv
logic/game_top.sv
verification/clk_gen.sv
verification/game_sva.sv
verification/game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the 2048 testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module game_tb -f game_2048.f -o game_sim \
	&& ./obj_dir/game_sim > sim.log 2>&1 \
	|| { echo "build or run error, see sim.log"; exit 1; }

grep -q "Simulation passed" sim.log \
	&& echo "run passed" \
	|| { echo "run failed, see sim.log"; exit 1; }
